// ==== verilog/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath widths
`define ADDR_LEN 32
`define DATA_LEN 32
`define INSN_LEN 32

// architectural register index
`define REG_SEL 5

// rob slots double as rename register tags
`define ROB_SEL 3
`define ROB_NUM 8

// reset pc
`define ENTRY_POINT 32'h0000_0000

`endif

// ==== verilog/core_pkg.sv ====
`include "core_consts.svh"

package core_pkg;

    // only the three major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    typedef enum logic {
        SRC_B_RS2 = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_sel_e;

    typedef struct packed {
        logic                 valid;
        logic [`ADDR_LEN-1:0] pc;
        logic [`INSN_LEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic                 valid;
        alu_op_e              alu_op;
        src_b_sel_e           src_b_sel;
        logic [`REG_SEL-1:0]  rs1;
        logic [`REG_SEL-1:0]  rs2;
        logic [`REG_SEL-1:0]  rd;
        logic                 wr_reg;
        logic [`DATA_LEN-1:0] imm;
        logic [`ADDR_LEN-1:0] pc;
    } id_dp_t;

    typedef struct packed {
        logic                 valid;
        alu_op_e              alu_op;
        logic [`DATA_LEN-1:0] op1;
        logic [`DATA_LEN-1:0] op2;
        logic [`ROB_SEL-1:0]  rrf_tag;
        logic                 wr_reg;
    } dp_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [`ROB_SEL-1:0]  rrf_tag;
        logic [`DATA_LEN-1:0] data;
    } ex_result_t;

    typedef struct packed {
        logic                 valid;
        logic                 we;
        logic [`REG_SEL-1:0]  rd;
        logic [`ROB_SEL-1:0]  rrf_tag;
        logic [`DATA_LEN-1:0] data;
    } commit_t;

endpackage

// ==== verilog/fetch_unit.sv ====
`include "core_consts.svh"

module fetch_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [`INSN_LEN-1:0] idata_i,
    output logic [`ADDR_LEN-1:0] iaddr_o,
    output core_pkg::if_id_t     if_o
);

    logic [`ADDR_LEN-1:0] pc_q;
    core_pkg::if_id_t     if_q;

    // without back-pressure the pc simply walks forward
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `ENTRY_POINT;
        end else begin
            pc_q <= pc_q + 4;
        end
    end

    assign iaddr_o = pc_q;

    // instruction word comes back in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            if_q.valid <= 1'b0;
        end else begin
            if_q.valid <= 1'b1;
            if_q.pc    <= pc_q;
            if_q.inst  <= idata_i;
        end
    end

    assign if_o = if_q;

endmodule

// ==== verilog/inst_decoder.sv ====
`include "core_consts.svh"

module inst_decoder (
    input  logic             clk_i,
    input  logic             rst_i,
    input  core_pkg::if_id_t if_i,
    output core_pkg::id_dp_t id_o
);

    core_pkg::opcode_e opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              legal;
    core_pkg::id_dp_t  id_d;
    core_pkg::id_dp_t  id_q;

    assign opcode = core_pkg::opcode_e'(if_i.inst[6:0]);
    assign funct3 = if_i.inst[14:12];
    assign funct7 = if_i.inst[31:25];

    always_comb begin
        id_d           = '0;
        id_d.pc        = if_i.pc;
        id_d.rs1       = if_i.inst[19:15];
        id_d.rs2       = if_i.inst[24:20];
        id_d.rd        = if_i.inst[11:7];
        id_d.imm       = {{20{if_i.inst[31]}}, if_i.inst[31:20]};
        id_d.alu_op    = core_pkg::ALU_ADD;
        id_d.src_b_sel = core_pkg::SRC_B_RS2;
        legal          = 1'b1;
        case (opcode)
            core_pkg::OPC_LUI: begin
                // rs1 forced to x0 so the first operand reads zero
                id_d.rs1       = '0;
                id_d.imm       = {if_i.inst[31:12], 12'b0};
                id_d.src_b_sel = core_pkg::SRC_B_IMM;
            end
            core_pkg::OPC_OP_IMM: begin
                id_d.src_b_sel = core_pkg::SRC_B_IMM;
                case (funct3)
                    3'b000:  id_d.alu_op = core_pkg::ALU_ADD;
                    3'b010:  id_d.alu_op = core_pkg::ALU_SLT;
                    3'b100:  id_d.alu_op = core_pkg::ALU_XOR;
                    3'b110:  id_d.alu_op = core_pkg::ALU_OR;
                    3'b111:  id_d.alu_op = core_pkg::ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            core_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: id_d.alu_op = core_pkg::ALU_ADD;
                    10'b0100000_000: id_d.alu_op = core_pkg::ALU_SUB;
                    10'b0000000_001: id_d.alu_op = core_pkg::ALU_SLL;
                    10'b0000000_010: id_d.alu_op = core_pkg::ALU_SLT;
                    10'b0000000_100: id_d.alu_op = core_pkg::ALU_XOR;
                    10'b0000000_101: id_d.alu_op = core_pkg::ALU_SRL;
                    10'b0000000_110: id_d.alu_op = core_pkg::ALU_OR;
                    10'b0000000_111: id_d.alu_op = core_pkg::ALU_AND;
                    default:         legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        // x0 as destination never claims a register
        id_d.wr_reg = legal && (id_d.rd != '0);
        id_d.valid  = if_i.valid && legal;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_q.valid <= 1'b0;
        end else begin
            id_q <= id_d;
        end
    end

    assign id_o = id_q;

endmodule

// ==== verilog/rename_unit.sv ====
`include "core_consts.svh"

module rename_unit (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  core_pkg::id_dp_t      id_i,
    input  logic [`ROB_SEL-1:0]   alloc_tag_i,
    input  core_pkg::ex_result_t  ex_i,
    input  core_pkg::commit_t     commit_i,
    output core_pkg::dp_ex_t      dp_o
);

    localparam int reg_num = 2 ** `REG_SEL;

    // architectural state plus rename mapping
    logic [`DATA_LEN-1:0] arf_data [reg_num];
    logic [`ROB_SEL-1:0]  arf_tag  [reg_num];
    logic [reg_num-1:0]   arf_busy;

    // rename registers, one per rob slot
    logic [`DATA_LEN-1:0] rrf_data [`ROB_NUM];
    logic [`ROB_NUM-1:0]  rrf_valid;

    logic                 dispatch_wr;
    logic                 commit_clear;
    core_pkg::dp_ex_t     dp_d;
    core_pkg::dp_ex_t     dp_q;

    // forwarding bus first, then rrf, then arf
    function automatic logic [`DATA_LEN-1:0] read_src(input logic [`REG_SEL-1:0] rs);
        logic [`ROB_SEL-1:0] tag;
        tag = arf_tag[rs];
        if (rs == '0) begin
            read_src = '0;
        end else if (arf_busy[rs] && ex_i.valid && ex_i.rrf_tag == tag) begin
            read_src = ex_i.data;
        end else if (arf_busy[rs] && rrf_valid[tag]) begin
            read_src = rrf_data[tag];
        end else begin
            read_src = arf_data[rs];
        end
    endfunction

    assign dispatch_wr  = id_i.valid && id_i.wr_reg;
    assign commit_clear = commit_i.valid && commit_i.we && arf_busy[commit_i.rd]
                          && (arf_tag[commit_i.rd] == commit_i.rrf_tag);

    always_comb begin
        dp_d.valid   = id_i.valid;
        dp_d.alu_op  = id_i.alu_op;
        dp_d.op1     = read_src(id_i.rs1);
        dp_d.op2     = (id_i.src_b_sel == core_pkg::SRC_B_IMM) ? id_i.imm : read_src(id_i.rs2);
        dp_d.rrf_tag = alloc_tag_i;
        dp_d.wr_reg  = id_i.wr_reg;
    end

    always_ff @(posedge clk_i) begin
        if (commit_i.valid && commit_i.we) begin
            arf_data[commit_i.rd] <= commit_i.data;
        end
        if (dispatch_wr) begin
            arf_tag[id_i.rd] <= alloc_tag_i;
        end
        if (ex_i.valid) begin
            rrf_data[ex_i.rrf_tag] <= ex_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            arf_busy  <= '0;
            rrf_valid <= '0;
        end else begin
            // younger dispatch to the same rd wins over the clear
            if (commit_clear) begin
                arf_busy[commit_i.rd] <= 1'b0;
            end
            if (dispatch_wr) begin
                arf_busy[id_i.rd] <= 1'b1;
            end
            if (ex_i.valid) begin
                rrf_valid[ex_i.rrf_tag] <= 1'b1;
            end
            if (id_i.valid) begin
                rrf_valid[alloc_tag_i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dp_q.valid <= 1'b0;
        end else begin
            dp_q <= dp_d;
        end
    end

    assign dp_o = dp_q;

    // rob may only retire a tag whose result already landed in the rrf
    assert property (@(posedge clk_i) disable iff (rst_i)
        commit_i.valid |-> rrf_valid[commit_i.rrf_tag])
        else $error("commit of tag %0d without rrf data", commit_i.rrf_tag);

endmodule

// ==== verilog/alu_exec.sv ====
`include "core_consts.svh"

module alu_exec (
    input  core_pkg::dp_ex_t     dp_i,
    output core_pkg::ex_result_t ex_o
);

    logic [`DATA_LEN-1:0] op1;
    logic [`DATA_LEN-1:0] op2;
    logic [4:0]           shamt;
    logic                 less;
    logic [`DATA_LEN-1:0] result;

    assign op1   = dp_i.op1;
    assign op2   = dp_i.op2;
    assign shamt = op2[4:0];
    assign less  = $signed(op1) < $signed(op2);

    always_comb begin
        case (dp_i.alu_op)
            core_pkg::ALU_ADD: begin
                result = op1 + op2;
            end
            core_pkg::ALU_SUB: begin
                result = op1 - op2;
            end
            core_pkg::ALU_AND: begin
                result = op1 & op2;
            end
            core_pkg::ALU_OR: begin
                result = op1 | op2;
            end
            core_pkg::ALU_XOR: begin
                result = op1 ^ op2;
            end
            core_pkg::ALU_SLT: begin
                result = {{(`DATA_LEN-1){1'b0}}, less};
            end
            core_pkg::ALU_SLL: begin
                result = op1 << shamt;
            end
            core_pkg::ALU_SRL: begin
                result = op1 >> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // result broadcast to rrf and rob in the same cycle
    assign ex_o.valid   = dp_i.valid;
    assign ex_o.rrf_tag = dp_i.rrf_tag;
    // no destination means x0, whose value is zero
    assign ex_o.data    = dp_i.wr_reg ? result : '0;

endmodule

// ==== verilog/rob_ctrl.sv ====
`include "core_consts.svh"

module rob_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  core_pkg::id_dp_t     id_i,
    input  core_pkg::ex_result_t ex_i,
    output logic [`ROB_SEL-1:0]  alloc_tag_o,
    output core_pkg::commit_t    commit_o
);

    logic [`ROB_SEL-1:0]  head_q;
    logic [`ROB_SEL-1:0]  tail_q;
    logic [`ROB_SEL:0]    count_q;
    logic [`ROB_NUM-1:0]  used_q;
    logic [`ROB_NUM-1:0]  done_q;

    // per-entry payload
    logic [`REG_SEL-1:0]  rd_mem   [`ROB_NUM];
    logic [`ROB_NUM-1:0]  wr_mem;
    logic [`DATA_LEN-1:0] data_mem [`ROB_NUM];

    logic                 alloc;
    logic                 retire;

    assign alloc       = id_i.valid;
    assign retire      = used_q[head_q] && done_q[head_q];
    assign alloc_tag_o = tail_q;

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            rd_mem[tail_q] <= id_i.rd;
            wr_mem[tail_q] <= id_i.wr_reg;
        end
        if (ex_i.valid) begin
            data_mem[ex_i.rrf_tag] <= ex_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            used_q   <= '0;
            done_q   <= '0;
            commit_o <= '0;
        end else begin
            if (retire) begin
                used_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            if (ex_i.valid) begin
                done_q[ex_i.rrf_tag] <= 1'b1;
            end
            if (alloc) begin
                used_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            count_q <= count_q + alloc - retire;
            // one in-order retirement per cycle
            commit_o.valid   <= retire;
            commit_o.we      <= retire && wr_mem[head_q];
            commit_o.rd      <= rd_mem[head_q];
            commit_o.rrf_tag <= head_q;
            commit_o.data    <= data_mem[head_q];
        end
    end

    // single alu and commit keep pace, so the rob never fills
    assert property (@(posedge clk_i) disable iff (rst_i)
        alloc |-> (count_q != (`ROB_SEL+1)'(`ROB_NUM)))
        else $error("rob allocation while full");

    assert property (@(posedge clk_i) disable iff (rst_i)
        ex_i.valid |-> used_q[ex_i.rrf_tag])
        else $error("completion on free rob entry %0d", ex_i.rrf_tag);

endmodule

// ==== verilog/ooo_core_top.sv ====
`include "core_consts.svh"

module ooo_core_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [`INSN_LEN-1:0] idata_i,
    output logic [`ADDR_LEN-1:0] iaddr_o,
    output logic                 commit_valid_o,
    output logic                 commit_we_o,
    output logic [`REG_SEL-1:0]  commit_rd_o,
    output logic [`DATA_LEN-1:0] commit_data_o
);

    core_pkg::if_id_t     if_id;
    core_pkg::id_dp_t     id_dp;
    core_pkg::dp_ex_t     dp_ex;
    core_pkg::ex_result_t ex_res;
    core_pkg::commit_t    commit;
    logic [`ROB_SEL-1:0]  alloc_tag;

    fetch_unit u_fetch_unit (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .idata_i(idata_i),
        .iaddr_o(iaddr_o),
        .if_o   (if_id)
    );

    inst_decoder u_inst_decoder (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .if_i (if_id),
        .id_o (id_dp)
    );

    rename_unit u_rename_unit (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .id_i       (id_dp),
        .alloc_tag_i(alloc_tag),
        .ex_i       (ex_res),
        .commit_i   (commit),
        .dp_o       (dp_ex)
    );

    alu_exec u_alu_exec (
        .dp_i(dp_ex),
        .ex_o(ex_res)
    );

    rob_ctrl u_rob_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .id_i       (id_dp),
        .ex_i       (ex_res),
        .alloc_tag_o(alloc_tag),
        .commit_o   (commit)
    );

    assign commit_valid_o = commit.valid;
    assign commit_we_o    = commit.we;
    assign commit_rd_o    = commit.rd;
    assign commit_data_o  = commit.data;

endmodule

// ==== verification/ooo_core_tb.sv ====
`include "core_consts.svh"

module ooo_core_tb;

    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [6:0] opc_op  = 7'b0110011;
    localparam logic [6:0] opc_lui = 7'b0110111;

    // all-zero word is an illegal encoding in RV32I
    localparam logic [`INSN_LEN-1:0] illegal_word = '0;

    typedef struct packed {
        logic [`INSN_LEN-1:0] insn;
        logic                 commit;
        logic [`REG_SEL-1:0]  rd;
        logic                 we;
        logic [`DATA_LEN-1:0] data;
    } row_t;

    logic                 clk;
    logic                 rst;
    logic [`INSN_LEN-1:0] idata;
    logic [`ADDR_LEN-1:0] iaddr;
    logic                 commit_valid;
    logic                 commit_we;
    logic [`REG_SEL-1:0]  commit_rd;
    logic [`DATA_LEN-1:0] commit_data;

    row_t prog[$];
    int   cyc = 0;
    int   limit = 0;
    int   n_pass = 0;
    int   n_fail = 0;
    int   n_other = 0;
    int   n_seen = 0;

    ooo_core_top u_dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .idata_i       (idata),
        .iaddr_o       (iaddr),
        .commit_valid_o(commit_valid),
        .commit_we_o   (commit_we),
        .commit_rd_o   (commit_rd),
        .commit_data_o (commit_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        r_type = {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        i_type = {imm, rs1, f3, rd, opc_imm};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        u_type = {imm, rd, opc_lui};
    endfunction

    task automatic add_row(input logic [31:0] insn, input logic commit, input logic [4:0] rd,
                           input logic we, input logic [31:0] data);
        prog.push_back('{insn, commit, rd, we, data});
    endtask

    // expected values worked out by hand from the ISA
    task automatic fill_table();
        add_row(u_type(1, 20'h12345), 1, 1, 1, 32'h1234_5000);
        add_row(i_type(3'b000, 2, 0, 12'd100), 1, 2, 1, 32'h0000_0064);
        add_row(i_type(3'b000, 3, 0, 12'hff9), 1, 3, 1, 32'hffff_fff9);
        add_row(r_type(7'h00, 3'b000, 4, 1, 2), 1, 4, 1, 32'h1234_5064);
        add_row(r_type(7'h20, 3'b000, 5, 2, 3), 1, 5, 1, 32'h0000_006b);
        add_row(r_type(7'h00, 3'b111, 6, 1, 3), 1, 6, 1, 32'h1234_5000);
        add_row(r_type(7'h00, 3'b110, 7, 2, 3), 1, 7, 1, 32'hffff_fffd);
        add_row(r_type(7'h00, 3'b100, 8, 2, 3), 1, 8, 1, 32'hffff_ff9d);
        add_row(r_type(7'h00, 3'b010, 9, 3, 2), 1, 9, 1, 32'h0000_0001);
        add_row(r_type(7'h00, 3'b010, 10, 2, 3), 1, 10, 1, 32'h0000_0000);
        // shift amount 100 keeps only its low 5 bits
        add_row(r_type(7'h00, 3'b001, 11, 1, 2), 1, 11, 1, 32'h2345_0000);
        add_row(r_type(7'h00, 3'b101, 13, 3, 2), 1, 13, 1, 32'h0fff_ffff);
        // back-to-back dependent chain
        add_row(i_type(3'b000, 14, 0, 12'd5), 1, 14, 1, 32'h0000_0005);
        add_row(i_type(3'b000, 14, 14, 12'd3), 1, 14, 1, 32'h0000_0008);
        add_row(r_type(7'h00, 3'b000, 15, 14, 14), 1, 15, 1, 32'h0000_0010);
        add_row(r_type(7'h20, 3'b000, 16, 15, 14), 1, 16, 1, 32'h0000_0008);
        add_row(i_type(3'b100, 17, 16, 12'h00f), 1, 17, 1, 32'h0000_0007);
        add_row(i_type(3'b110, 18, 17, 12'h100), 1, 18, 1, 32'h0000_0107);
        add_row(i_type(3'b111, 19, 18, 12'h0ff), 1, 19, 1, 32'h0000_0007);
        add_row(i_type(3'b010, 20, 19, 12'd8), 1, 20, 1, 32'h0000_0001);
        // long retired sources from the arf
        add_row(i_type(3'b010, 21, 3, 12'hff8), 1, 21, 1, 32'h0000_0000);
        add_row(i_type(3'b000, 22, 1, 12'd1), 1, 22, 1, 32'h1234_5001);
        // x23 renamed twice while both are in flight
        add_row(i_type(3'b000, 23, 0, 12'd11), 1, 23, 1, 32'h0000_000b);
        add_row(i_type(3'b000, 23, 0, 12'd22), 1, 23, 1, 32'h0000_0016);
        add_row(r_type(7'h00, 3'b000, 24, 23, 0), 1, 24, 1, 32'h0000_0016);
        add_row(i_type(3'b000, 0, 2, 12'd55), 1, 0, 0, 32'h0000_0000);
        add_row(r_type(7'h00, 3'b000, 25, 0, 23), 1, 25, 1, 32'h0000_0016);
        add_row(32'hffff_ffff, 0, 0, 0, 32'h0);
        add_row(u_type(26, 20'habcde), 1, 26, 1, 32'habcd_e000);
        add_row(r_type(7'h00, 3'b000, 27, 26, 25), 1, 27, 1, 32'habcd_e016);
        // funct7 of sub with funct3 of and
        add_row(r_type(7'h20, 3'b111, 28, 1, 1), 0, 0, 0, 32'h0);
        add_row(r_type(7'h00, 3'b100, 28, 27, 26), 1, 28, 1, 32'h0000_0016);
        add_row(r_type(7'h00, 3'b110, 29, 0, 0), 1, 29, 1, 32'h0000_0000);
        add_row(r_type(7'h20, 3'b000, 30, 0, 4), 1, 30, 1, 32'hedcb_af9c);
    endtask

    function automatic logic [`INSN_LEN-1:0] fetch_word(input logic [`ADDR_LEN-1:0] addr);
        logic [`ADDR_LEN-1:0] idx;
        idx = (addr - `ENTRY_POINT) >> 2;
        if ($isunknown(addr) || idx >= prog.size()) begin
            fetch_word = illegal_word;
        end else begin
            fetch_word = prog[idx].insn;
        end
    endfunction

    // instruction memory answers for the address of the current cycle
    always @(negedge clk) begin
        idata <= fetch_word(iaddr);
    end

    always @(posedge clk) begin
        if (!rst) begin
            cyc = cyc + 1;
            if (cyc >= limit) begin
                $display("timeout after %0d cycles, only %0d commits seen", cyc, n_seen);
                $display("TESTBENCH FAILED");
                $finish;
            end
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            assert (commit_valid === 1'b0 && iaddr === `ENTRY_POINT) else begin
                $display("FAIL %0t: commit_valid or iaddr wrong during reset", $time);
                n_other++;
            end
        end else begin
            assert (iaddr === `ENTRY_POINT + 4 * cyc) else begin
                $display("FAIL %0t: iaddr %h in cycle %0d", $time, iaddr, cyc);
                n_other++;
            end
            if (cyc < 5) begin
                assert (commit_valid === 1'b0) else begin
                    $display("FAIL %0t: commit before the pipeline could fill", $time);
                    n_other++;
                end
            end
        end
    end

    task automatic wait_commit();
        do begin
            @(negedge clk);
        end while (commit_valid !== 1'b1);
        n_seen++;
    endtask

    initial begin
        row_t row;
        logic bad;
        clk   = 1'b0;
        rst   = 1'b1;
        idata = illegal_word;
        fill_table();
        limit = prog.size() + 5 + 20;
        repeat (4) @(negedge clk);
        rst <= 1'b0;

        for (int i = 0; i < prog.size(); i++) begin
            row = prog[i];
            bad = 1'b0;
            if (row.commit) begin
                wait_commit();
                // fetch of row i is in cycle i, so commit lands in cycle i + 5
                assert (cyc == i + 5) else begin
                    $display("FAIL %0t: test %0d commit in cycle %0d, not %0d",
                             $time, i, cyc, i + 5);
                    bad = 1'b1;
                end
                assert (commit_rd === row.rd) else begin
                    $display("FAIL %0t: test %0d rd %0d, expected %0d",
                             $time, i, commit_rd, row.rd);
                    bad = 1'b1;
                end
                assert (commit_we === row.we) else begin
                    $display("FAIL %0t: test %0d we %b, expected %b",
                             $time, i, commit_we, row.we);
                    bad = 1'b1;
                end
                assert (commit_data === row.data) else begin
                    $display("FAIL %0t: test %0d data %h, expected %h",
                             $time, i, commit_data, row.data);
                    bad = 1'b1;
                end
                $display("test %2d: x%0d = %h %s", i, row.rd, row.data, bad ? "mismatch" : "ok");
            end else begin
                // the commit slot of an illegal word stays empty
                while (cyc < i + 5) begin
                    @(negedge clk);
                end
                assert (commit_valid === 1'b0) else begin
                    $display("FAIL %0t: test %0d illegal word committed to rd %0d",
                             $time, i, commit_rd);
                    bad = 1'b1;
                end
                $display("test %2d: illegal word, no commit %s", i, bad ? "mismatch" : "ok");
            end
            if (bad) begin
                n_fail++;
            end else begin
                n_pass++;
            end
        end

        // only illegal words follow the table
        repeat (8) begin
            @(negedge clk);
            assert (commit_valid === 1'b0) else begin
                $display("FAIL %0t: unexpected commit of rd %0d after the table",
                         $time, commit_rd);
                n_other++;
            end
        end

        $display("tests: %0d passed, %0d failed, %0d other errors", n_pass, n_fail, n_other);
        if (n_fail == 0 && n_other == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/inst_decoder.sv
verilog/rename_unit.sv
verilog/alu_exec.sv
verilog/rob_ctrl.sv
verilog/ooo_core_top.sv
verification/ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_pkg.sv
      - verilog/fetch_unit.sv
      - verilog/inst_decoder.sv
      - verilog/rename_unit.sv
      - verilog/alu_exec.sv
      - verilog/rob_ctrl.sv
      - verilog/ooo_core_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/ooo_core_tb.sv
